// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module pc_cfg_tb -o pc_cfg_sim
	./obj_dir/pc_cfg_sim > sim.log 2>&1; cat sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
+incdir+hdl
hdl/pc_cfg_pkg.sv
hdl/pc_word_parser.sv
hdl/beat_counter.sv
hdl/chan_assembler.sv
hdl/hold_buf.sv
hdl/pc_cfg_top.sv
sim/pc_cfg_chk.sv
sim/pc_cfg_monitor.sv
sim/pc_cfg_tb.sv

// ==== hdl/beat_counter.sv ====
`include "pc_cfg_params.svh"

module beat_counter
  import pc_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // one accepted beat on step_chan
  input  logic     step,
  input  chan_id_t step_chan,

  // selected channel is at its final beat
  output logic     last
);

  localparam int CNT_W = (`CHAN_BEATS > 1) ? $clog2(`CHAN_BEATS) : 1;

  // one beat count per channel
  logic [CNT_W-1:0] count [`NCHAN];

  // looks at the selected channel only
  assign last = count[step_chan] == CNT_W'(`CHAN_BEATS - 1);

  // advance the stepped channel, wrap after its final beat
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `NCHAN; i++) begin
        count[i] <= '0;
      end
    end else if (step) begin
      for (int i = 0; i < `NCHAN; i++) begin
        if (step_chan == chan_id_t'(i)) begin
          if (last) begin
            count[i] <= '0;
          end else begin
            count[i] <= count[i] + 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== hdl/chan_assembler.sv ====
`include "pc_cfg_params.svh"

module chan_assembler
  import pc_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  // beats from the parser
  input  logic        beat_v,
  input  chan_id_t    beat_chan,
  input  conf_t       beat_data,
  output logic        beat_a,

  // assembled values, to the channel holding buffer
  output logic        out_v,
  output chan_value_t out_value,
  input  logic        out_a
);

  // earlier beats of a value, the final one comes straight from the input
  localparam int SR_W   = `NCONF * (`CHAN_BEATS - 1);
  localparam int FULL_W = `NCONF * `CHAN_BEATS;

  logic [SR_W-1:0]   shift_regs [`NCHAN];
  logic [FULL_W-1:0] full_value;
  logic [SR_W-1:0]   shift_next;
  logic              last;
  logic              beat_take;

  //////////////////////////////////////////////////
  // beat bookkeeping
  //////////////////////////////////////////////////

  assign beat_take = beat_v && beat_a;

  beat_counter u_beat_counter (
    .clk       (clk),
    .reset     (reset),
    .step      (beat_take),
    .step_chan (beat_chan),
    .last      (last)
  );

  //////////////////////////////////////////////////
  // assembly
  //////////////////////////////////////////////////

  // newest beat on top, so the first beat ends up in the low half
  assign full_value = {beat_data, shift_regs[beat_chan]};
  assign shift_next = full_value[FULL_W-1 -: SR_W];

  // only non-final beats go into the shift register
  always_ff @(posedge clk) begin
    if (beat_take && !last) begin
      shift_regs[beat_chan] <= shift_next;
    end
  end

  // a final beat leaves in the same cycle it is taken
  assign out_v           = beat_v && last;
  assign out_value.chan  = beat_chan;
  assign out_value.value = full_value;

  // non-final beats never wait; the final one waits for room downstream
  assign beat_a = beat_v && (!last || out_a);

endmodule

// ==== hdl/hold_buf.sv ====
module hold_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,

  // upstream side
  input  logic     in_v,
  input  payload_t in_d,
  output logic     in_a,

  // downstream side
  output logic     out_v,
  output payload_t out_d,
  input  logic     out_a
);

  logic full;

  //////////////////////////////////////////////////
  // single entry slice
  //////////////////////////////////////////////////

  // room when empty, or when the held item leaves this cycle
  // so a steady stream moves one item per cycle
  assign in_a  = !full || out_a;
  assign out_v = full;

  // whenever there is room, the slot takes whatever is offered
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_a) begin
      full <= in_v;
    end
  end

  // payload only moves on a transfer in
  always_ff @(posedge clk) begin
    if (in_v && in_a) begin
      out_d <= in_d;
    end
  end

endmodule

// ==== hdl/pc_cfg_params.svh ====
`ifndef PC_CFG_PARAMS_SVH
`define PC_CFG_PARAMS_SVH

//////////////////////////////////////////////////
// widths and counts of the config front end
//////////////////////////////////////////////////

// host word width
`define PC_WIDTH 32

// width of one config register, also one channel beat
`define NCONF 16

// number of config registers, addressed by the low id bits
`define NREG 16

// number of config channels
`define NCHAN 2

// beats that make up one channel value, low half first
`define CHAN_BEATS 2

// BD word fields
`define BD_PAYLOAD 20
`define LEAF_W 6

`endif

// ==== hdl/pc_cfg_pkg.sv ====
`include "pc_cfg_params.svh"

package pc_cfg_pkg;

  //////////////////////////////////////////////////
  // host side
  //////////////////////////////////////////////////

  // one raw word from the host
  typedef logic [`PC_WIDTH-1:0] pc_word_t;

  // destination of a host word, from its top bits
  // 0x -> BD, 10 -> register, 11 -> channel
  typedef enum logic [1:0] {
    bd_word,
    reg_word,
    chan_word
  } word_kind_t;

  // one register value, also one channel beat
  typedef logic [`NCONF-1:0] conf_t;

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  // BD-bound word, leaf code on top
  typedef struct packed {
    logic [`LEAF_W-1:0]     leaf;
    logic [`BD_PAYLOAD-1:0] payload;
  } bd_word_t;

  // channel index, only as wide as NCHAN needs
  localparam int CHAN_ID_W = $clog2(`NCHAN);
  typedef logic [CHAN_ID_W-1:0] chan_id_t;

  // assembled channel value, first beat in the low bits
  typedef struct packed {
    chan_id_t                       chan;
    logic [`NCONF*`CHAN_BEATS-1:0] value;
  } chan_value_t;

endpackage

// ==== hdl/pc_cfg_top.sv ====
`include "pc_cfg_params.svh"

module pc_cfg_top
  import pc_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              reset,

  // host words
  input  logic              pc_v,
  input  pc_word_t          pc_d,
  output logic              pc_a,

  // config registers
  output conf_t [`NREG-1:0] conf_regs,

  // chip-side BD port
  output logic              bd_v,
  output bd_word_t          bd_word,
  input  logic              bd_a,

  // shared channel output
  output logic              chan_v,
  output chan_value_t       chan_out,
  input  logic              chan_a
);

  // parser to BD buffer
  logic        bd_in_v;
  bd_word_t    bd_in;
  logic        bd_in_a;

  // parser to assembler
  logic        beat_v;
  chan_id_t    beat_chan;
  conf_t       beat_data;
  logic        beat_a;

  // assembler to channel buffer
  logic        asm_v;
  chan_value_t asm_value;
  logic        asm_a;

  //////////////////////////////////////////////////
  // word decode and steering
  //////////////////////////////////////////////////

  pc_word_parser u_parser (
    .clk       (clk),
    .reset     (reset),
    .pc_v      (pc_v),
    .pc_d      (pc_d),
    .pc_a      (pc_a),
    .conf_regs (conf_regs),
    .bd_in_v   (bd_in_v),
    .bd_in     (bd_in),
    .bd_in_a   (bd_in_a),
    .beat_v    (beat_v),
    .beat_chan (beat_chan),
    .beat_data (beat_data),
    .beat_a    (beat_a)
  );

  // BD path, one cycle through the slice
  hold_buf #(.payload_t(bd_word_t)) u_bd_buf (
    .clk   (clk),
    .reset (reset),
    .in_v  (bd_in_v),
    .in_d  (bd_in),
    .in_a  (bd_in_a),
    .out_v (bd_v),
    .out_d (bd_word),
    .out_a (bd_a)
  );

  //////////////////////////////////////////////////
  // channel path
  //////////////////////////////////////////////////

  chan_assembler u_assembler (
    .clk       (clk),
    .reset     (reset),
    .beat_v    (beat_v),
    .beat_chan (beat_chan),
    .beat_data (beat_data),
    .beat_a    (beat_a),
    .out_v     (asm_v),
    .out_value (asm_value),
    .out_a     (asm_a)
  );

  hold_buf #(.payload_t(chan_value_t)) u_chan_buf (
    .clk   (clk),
    .reset (reset),
    .in_v  (asm_v),
    .in_d  (asm_value),
    .in_a  (asm_a),
    .out_v (chan_v),
    .out_d (chan_out),
    .out_a (chan_a)
  );

endmodule

// ==== hdl/pc_word_parser.sv ====
`include "pc_cfg_params.svh"

module pc_word_parser
  import pc_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,

  // host words
  input  logic                 pc_v,
  input  pc_word_t             pc_d,
  output logic                 pc_a,

  // config registers
  output conf_t [`NREG-1:0]    conf_regs,

  // BD-bound words, to the BD holding buffer
  output logic                 bd_in_v,
  output bd_word_t             bd_in,
  input  logic                 bd_in_a,

  // channel beats, to the assembler
  output logic                 beat_v,
  output chan_id_t             beat_chan,
  output conf_t                beat_data,
  input  logic                 beat_a
);

  //////////////////////////////////////////////////
  // field split
  //////////////////////////////////////////////////

  // register / channel word
  //   [31:30] kind  [29:24] id  [23:16] unused  [15:0] data
  // BD word
  //   [31:30] 0x  [29:24] leaf  [23:20] unused  [19:0] payload

  logic [1:0]               kind_bits;
  logic [$clog2(`NREG)-1:0] reg_sel;
  chan_id_t                 chan_sel;
  conf_t                    conf_data;
  bd_word_t                 bd_fields;
  word_kind_t               kind;

  assign kind_bits = pc_d[`PC_WIDTH-1 -: 2];

  // only the low id bits select, higher ids alias
  assign reg_sel  = pc_d[`PC_WIDTH-8 +: $clog2(`NREG)];
  assign chan_sel = pc_d[`PC_WIDTH-8 +: CHAN_ID_W];

  assign conf_data = pc_d[`NCONF-1:0];

  // leaf sits right below the kind bits, same place as the id
  assign bd_fields.leaf    = pc_d[`PC_WIDTH-3 -: `LEAF_W];
  assign bd_fields.payload = pc_d[`BD_PAYLOAD-1:0];

  // top bit 0 means BD, whatever the next bit is
  always_comb begin
    if (!kind_bits[1]) begin
      kind = bd_word;
    end else if (!kind_bits[0]) begin
      kind = reg_word;
    end else begin
      kind = chan_word;
    end
  end

  //////////////////////////////////////////////////
  // config registers
  //////////////////////////////////////////////////

  // register words never stall, so pc_v alone marks the write
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      conf_regs <= '0;
    end else if (pc_v && kind == reg_word) begin
      conf_regs[reg_sel] <= conf_data;
    end
  end

  //////////////////////////////////////////////////
  // steering
  //////////////////////////////////////////////////

  // at most one of the two downstream valids is high
  assign bd_in_v = pc_v && kind == bd_word;
  assign bd_in   = bd_fields;

  assign beat_v    = pc_v && kind == chan_word;
  assign beat_chan = chan_sel;
  assign beat_data = conf_data;

  // ack comes back from whichever side the word is going to
  always_comb begin
    pc_a = 1'b0;
    if (pc_v) begin
      case (kind)
        bd_word:   pc_a = bd_in_a;
        reg_word:  pc_a = 1'b1;
        chan_word: pc_a = beat_a;
        default:   pc_a = 1'b0;
      endcase
    end
  end

endmodule

// ==== sim/pc_cfg_chk.sv ====
module pc_cfg_chk
  import pc_cfg_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic        pc_v,
  input logic        pc_a,
  input logic        bd_v,
  input bd_word_t    bd_word,
  input logic        bd_a,
  input logic        chan_v,
  input chan_value_t chan_out,
  input logic        chan_a
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // handshake rules
  //////////////////////////////////////////////////

  // host ack only ever answers a valid word
  ack_needs_valid: assert property (
    @(posedge clk) disable iff (reset) pc_a |-> pc_v
  ) else $error("pc_a high without pc_v");

  // a stalled BD word holds still until taken
  bd_held: assert property (
    @(posedge clk) disable iff (reset) bd_v && !bd_a |=> bd_v && $stable(bd_word)
  ) else $error("bd_v or bd_word changed before bd_a");

  // same for the shared channel port
  chan_held: assert property (
    @(posedge clk) disable iff (reset) chan_v && !chan_a |=> chan_v && $stable(chan_out)
  ) else $error("chan_v or chan_out changed before chan_a");

  // nothing leaves while in reset
  quiet_in_reset: assert property (
    @(posedge clk) reset |-> !pc_a && !bd_v && !chan_v
  ) else $error("output active during reset");

endmodule

bind pc_cfg_top pc_cfg_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .pc_v     (pc_v),
  .pc_a     (pc_a),
  .bd_v     (bd_v),
  .bd_word  (bd_word),
  .bd_a     (bd_a),
  .chan_v   (chan_v),
  .chan_out (chan_out),
  .chan_a   (chan_a)
);

// ==== sim/pc_cfg_input.txt ====
# W word : host word to send, hex
# B leaf payload / C chan value / R index value : expected outputs, hex
W 83001234
R 3 1234
W 93005678
R 3 5678
W BF00BEEF
R f beef
W 150ABCDE
B 15 abcde
W 7FF00001
B 3f 00001
W 22012345
B 22 12345
W C0001111
W C0002222
C 0 22221111
W C0003333
W C1004444
W C0005555
W C1006666
C 0 55553333
C 1 66664444
W 01000001
B 01 00001
W 85000042
R 5 0042
W C1007777

// ==== sim/pc_cfg_monitor.sv ====
`include "pc_cfg_params.svh"

module pc_cfg_monitor
  import pc_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              pc_v,
  input  pc_word_t          pc_d,
  input  logic              pc_a,
  input  conf_t [`NREG-1:0] conf_regs,
  input  logic              bd_v,
  input  bd_word_t          bd_word,
  input  logic              bd_a,
  input  logic              chan_v,
  input  chan_value_t       chan_out,
  input  logic              chan_a,
  output int                mismatches,
  output int                other_errors,
  output int                pending
);

  timeunit 1ns;
  timeprecision 100ps;

  // expected events, one queue per output kind
  logic [31:0] bd_leaf_q[$];
  logic [31:0] bd_pay_q[$];
  logic [31:0] chan_id_q[$];
  logic [31:0] chan_val_q[$];
  logic [31:0] reg_idx_q[$];
  logic [31:0] reg_val_q[$];

  // register file as the R lines say it should look
  conf_t exp_regs [`NREG];
  logic  reg_pending;
  logic  reset_checked;

  //////////////////////////////////////////////////
  // expected events from the data file
  //////////////////////////////////////////////////

  initial begin
    int        fd;
    int        n;
    string     line;
    byte       tag;
    logic [31:0] a;
    logic [31:0] b;
    mismatches    = 0;
    other_errors  = 0;
    reg_pending   = 0;
    reset_checked = 0;
    for (int i = 0; i < `NREG; i++) begin
      exp_regs[i] = '0;
    end
    fd = $fopen("sim/pc_cfg_input.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/pc_cfg_input.txt for expected events");
      other_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%c %h %h", tag, a, b);
        // W lines belong to the driver
        if (n == 3 && tag == "B") begin
          bd_leaf_q.push_back(a);
          bd_pay_q.push_back(b);
        end else if (n == 3 && tag == "C") begin
          chan_id_q.push_back(a);
          chan_val_q.push_back(b);
        end else if (n == 3 && tag == "R") begin
          reg_idx_q.push_back(a);
          reg_val_q.push_back(b);
        end
      end
      $fclose(fd);
    end
    pending = bd_leaf_q.size() + chan_id_q.size() + reg_idx_q.size();
  end

  //////////////////////////////////////////////////
  // compare, mid-cycle where everything is settled
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      // first cycle out of reset
      if (!reset_checked) begin
        reset_checked = 1;
        if (conf_regs !== '0 || bd_v !== 1'b0 || chan_v !== 1'b0) begin
          $display("MISMATCH at %0t: registers or valids not clear after reset", $time);
          mismatches++;
        end
      end
      // register accepted last cycle, now visible
      if (reg_pending) begin
        reg_pending = 0;
        if (reg_idx_q.size() == 0) begin
          $display("register word written with no R line expected, at %0t", $time);
          other_errors++;
        end else begin
          exp_regs[reg_idx_q.pop_front()] = conf_t'(reg_val_q.pop_front());
          for (int i = 0; i < `NREG; i++) begin
            if (conf_regs[i] !== exp_regs[i]) begin
              $display("MISMATCH at %0t: conf_regs[%0d] = %h, expected %h",
                       $time, i, conf_regs[i], exp_regs[i]);
              mismatches++;
            end
          end
        end
      end
      // register words go through whatever the BD and channel sides do
      if (pc_v && pc_d[31:30] == 2'b10 && pc_a !== 1'b1) begin
        $display("MISMATCH at %0t: pc_a low for an offered register word", $time);
        mismatches++;
      end
      if (pc_v && pc_a && pc_d[31:30] == 2'b10) begin
        reg_pending = 1;
      end
      // BD port transfer at the coming edge
      if (bd_v && bd_a) begin
        if (bd_leaf_q.size() == 0) begin
          $display("extra BD transfer at %0t, nothing more was expected", $time);
          other_errors++;
        end else begin
          a_cmp_bd : begin
            logic [31:0] leaf;
            logic [31:0] pay;
            leaf = bd_leaf_q.pop_front();
            pay  = bd_pay_q.pop_front();
            if (bd_word.leaf !== leaf[`LEAF_W-1:0] ||
                bd_word.payload !== pay[`BD_PAYLOAD-1:0]) begin
              $display("MISMATCH at %0t: bd leaf %h payload %h, expected %h %h",
                       $time, bd_word.leaf, bd_word.payload, leaf, pay);
              mismatches++;
            end
          end
        end
      end
      // channel port transfer at the coming edge
      if (chan_v && chan_a) begin
        if (chan_id_q.size() == 0) begin
          $display("extra channel transfer at %0t, nothing more was expected", $time);
          other_errors++;
        end else begin
          a_cmp_chan : begin
            logic [31:0] id;
            logic [31:0] val;
            id  = chan_id_q.pop_front();
            val = chan_val_q.pop_front();
            if (chan_out.chan !== chan_id_t'(id) || chan_out.value !== val) begin
              $display("MISMATCH at %0t: chan %0d value %h, expected %0d %h",
                       $time, chan_out.chan, chan_out.value, id, val);
              mismatches++;
            end
          end
        end
      end
      pending = bd_leaf_q.size() + chan_id_q.size() + reg_idx_q.size() + int'(reg_pending);
    end
  end

endmodule

// ==== sim/pc_cfg_tb.sv ====
`include "pc_cfg_params.svh"

module pc_cfg_tb
  import pc_cfg_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  logic              clk;
  logic              reset;
  logic              pc_v;
  pc_word_t          pc_d;
  logic              pc_a;
  conf_t [`NREG-1:0] conf_regs;
  logic              bd_v;
  bd_word_t          bd_word;
  logic              bd_a;
  logic              chan_v;
  chan_value_t       chan_out;
  logic              chan_a;

  int       mismatches;
  int       other_errors;
  int       pending;
  int       cycle_count;
  int       cycle_limit;
  pc_word_t words[$];

  // current word is a BD word with a register word right behind it
  logic     bd_hold;

  pc_cfg_top uut (.*);

  pc_cfg_monitor u_monitor (.*);

  //////////////////////////////////////////////////
  // clock, back-pressure, timeout
  //////////////////////////////////////////////////

  initial begin
    clk = 0;
    forever #10 clk = ~clk;
  end

  // outputs stall about 30% of cycles
  initial begin
    logic stall_bd;
    bd_a     = 0;
    chan_a   = 0;
    stall_bd = 0;
    void'($urandom(15));
    forever begin
      // hold bd_a low one cycle when such a BD word is taken
      @(negedge clk);
      stall_bd = bd_hold && pc_v && pc_a && !pc_d[`PC_WIDTH-1];
      @(posedge clk);
      #1;
      bd_a   = ($urandom % 100) >= 30 && !stall_bd;
      chan_a = ($urandom % 100) >= 30;
    end
  end

  initial begin
    cycle_count = 0;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, %0d expected events never seen",
               cycle_count, pending);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // host side driver
  //////////////////////////////////////////////////

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send_word(input pc_word_t w);
    logic taken;
    pc_v  = 1;
    pc_d  = w;
    taken = 0;
    while (!taken) begin
      // ack is settled mid-cycle
      @(negedge clk);
      taken = pc_a;
      @(posedge clk);
    end
    #1;
  endtask

  task automatic load_words();
    int        fd;
    int        n;
    string     line;
    byte       tag;
    logic [31:0] w;
    fd = $fopen("sim/pc_cfg_input.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%c %h", tag, w);
        if (n == 2 && tag == "W") begin
          words.push_back(w);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    reset   = 1;
    pc_v    = 0;
    pc_d    = '0;
    bd_hold = 0;
    load_words();
    cycle_limit = 20 * words.size() + 200;
    repeat (16) @(posedge clk);
    #1;
    reset = 0;
    foreach (words[i]) begin
      // the register word then meets a stalled BD port
      bd_hold = 0;
      if (i + 1 < words.size()) begin
        bd_hold = !words[i][`PC_WIDTH-1] && words[i+1][`PC_WIDTH-1 -: 2] == 2'b10;
      end
      send_word(words[i]);
    end
    bd_hold = 0;
    pc_v    = 0;
    pc_d    = '0;
    // drain, then leave room for stray transfers
    while (pending > 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0 && words.size() > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
